// ==== dual_issue_pkg.sv ====
package dual_issue_pkg;

    // Datapath widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_N      = 1 << REG_ADDR_W;

    // Two issue slots, two source operands per slot
    localparam int ISSUE_W = 2;
    localparam int SRC_N   = 2;
    localparam int RD_N    = ISSUE_W * SRC_N;

    // Forwarding sources, index 0 has the highest priority:
    // [0] ex1, [1] ex0, [2] mem1, [3] mem0
    localparam int FWD_N = 4;

    // Instruction classes as seen by the issue logic
    typedef enum logic [2:0] {
        OP_ALU  = 3'd0,
        OP_MEM  = 3'd1,
        OP_CSR  = 3'd2,
        OP_PRIV = 3'd3,
        OP_TRAP = 3'd4
    } op_class_e;

    // Decoded instruction from the instruction buffer
    typedef struct packed {
        logic                                 valid;
        logic [31:0]                          pc;
        op_class_e                            op_class;
        logic [7:0]                           aluop;
        logic [SRC_N-1:0]                     read_valid;
        logic [SRC_N-1:0][REG_ADDR_W-1:0]     read_addr;
        logic                                 write_valid;
        logic [REG_ADDR_W-1:0]                write_addr;
        logic                                 use_imm;
        logic [DATA_W-1:0]                    imm;
    } slot_t;

    // Result forwarded from a later pipeline stage
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } fwd_t;

    // Register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } wb_t;

    // Instruction handed to execute
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        op_class_e             op_class;
        logic [7:0]            aluop;
        logic                  write_valid;
        logic [REG_ADDR_W-1:0] write_addr;
        logic [DATA_W-1:0]     operand1;
        logic [DATA_W-1:0]     operand2;
        logic [DATA_W-1:0]     imm;
    } issue_t;

endpackage

// ==== issue_ctrl.sv ====
`timescale 1ns/100ps

module issue_ctrl (
    input  dual_issue_pkg::slot_t [dual_issue_pkg::ISSUE_W-1:0] slot_i,
    input  logic                                                stall_i,
    input  logic                                                flush_i,
    input  logic                                                block_i,
    output logic [dual_issue_pkg::ISSUE_W-1:0]                  issue_mask_o,
    output logic [dual_issue_pkg::ISSUE_W-1:0]                  accept_o,
    output logic                                                is_pri_o
);

    logic [dual_issue_pkg::ISSUE_W-1:0] slot_valid;
    logic [dual_issue_pkg::ISSUE_W-1:0] mask;
    logic                               raw_hazard;
    logic                               slot0_serial;
    logic                               any_mem;
    logic                               slot1_trap;

    assign slot_valid = {slot_i[1].valid, slot_i[0].valid};

    // Slot 1 source matches slot 0 destination
    always_comb begin
        raw_hazard = 1'b0;
        for (int r = 0; r < dual_issue_pkg::SRC_N; r++) begin
            if (slot_i[1].read_valid[r] && slot_i[0].write_valid &&
                slot_i[1].read_addr[r] == slot_i[0].write_addr) begin
                raw_hazard = 1'b1;
            end
        end
    end

    assign slot0_serial = (slot_i[0].op_class == dual_issue_pkg::OP_PRIV) ||
                          (slot_i[0].op_class == dual_issue_pkg::OP_CSR);
    assign any_mem      = (slot_i[0].op_class == dual_issue_pkg::OP_MEM) ||
                          (slot_i[1].op_class == dual_issue_pkg::OP_MEM);
    assign slot1_trap   = (slot_i[1].op_class == dual_issue_pkg::OP_TRAP);

    always_comb begin
        if (block_i) begin
            mask = 2'b00;
        end else if (raw_hazard) begin
            mask = 2'b01;
        end else if (slot0_serial) begin
            mask = 2'b01;
        end else if (any_mem) begin
            mask = 2'b01;
        end else if (slot1_trap) begin
            mask = 2'b01;
        end else begin
            mask = 2'b11;
        end
    end

    assign issue_mask_o = mask & slot_valid;

    // Single issue also drains an empty slot 1 from the buffer
    always_comb begin
        if (stall_i) begin
            accept_o = 2'b00;
        end else if (issue_mask_o == 2'b01) begin
            accept_o = {~slot_valid[1], 1'b1};
        end else begin
            accept_o = issue_mask_o;
        end
    end

    assign is_pri_o = (slot_i[0].op_class == dual_issue_pkg::OP_PRIV) && issue_mask_o[0] &&
                      !stall_i && !flush_i;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  dual_issue_pkg::wb_t [dual_issue_pkg::ISSUE_W-1:0]      wb_i,
    input  logic [dual_issue_pkg::RD_N-1:0][dual_issue_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [dual_issue_pkg::RD_N-1:0][dual_issue_pkg::DATA_W-1:0]     rdata_o
);

    logic [dual_issue_pkg::REG_N-1:0][dual_issue_pkg::DATA_W-1:0] regs;

    // Port 1 is applied last so it wins on an address clash
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int p = 0; p < dual_issue_pkg::ISSUE_W; p++) begin
                if (wb_i[p].we && wb_i[p].addr != '0) begin
                    regs[wb_i[p].addr] <= wb_i[p].data;
                end
            end
        end
    end

    // Reads see the value before this edge's writes
    generate
        for (genvar p = 0; p < dual_issue_pkg::RD_N; p++) begin : g_read
            assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    endgenerate

endmodule

// ==== operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  logic                                             rd_valid_i,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0]            rd_addr_i,
    input  logic [dual_issue_pkg::DATA_W-1:0]                rf_data_i,
    input  dual_issue_pkg::fwd_t [dual_issue_pkg::FWD_N-1:0] fwd_i,
    output logic [dual_issue_pkg::DATA_W-1:0]                operand_o
);

    logic lookup;

    // Register 0 is never forwarded
    assign lookup = rd_valid_i && (rd_addr_i != '0);

    // Walk from the lowest priority source up, so the last match wins
    always_comb begin
        operand_o = rf_data_i;
        for (int i = dual_issue_pkg::FWD_N - 1; i >= 0; i--) begin
            if (lookup && fwd_i[i].valid && fwd_i[i].addr == rd_addr_i) begin
                operand_o = fwd_i[i].data;
            end
        end
    end

endmodule

// ==== dispatch_regs.sv ====
`timescale 1ns/100ps

module dispatch_regs (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  dual_issue_pkg::slot_t [dual_issue_pkg::ISSUE_W-1:0]   slot_i,
    input  logic [dual_issue_pkg::ISSUE_W-1:0][dual_issue_pkg::SRC_N-1:0][dual_issue_pkg::DATA_W-1:0]
                                                                  operand_i,
    input  logic [dual_issue_pkg::ISSUE_W-1:0]                    issue_mask_i,
    input  logic                                                  stall_i,
    input  logic                                                  flush_i,
    output dual_issue_pkg::issue_t [dual_issue_pkg::ISSUE_W-1:0]  exe_o
);

    generate
        for (genvar s = 0; s < dual_issue_pkg::ISSUE_W; s++) begin : g_slot
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    exe_o[s] <= '0;
                end else if (flush_i) begin
                    exe_o[s] <= '0;
                end else if (stall_i) begin
                    exe_o[s] <= exe_o[s];
                end else if (issue_mask_i[s]) begin
                    exe_o[s].valid       <= 1'b1;
                    exe_o[s].pc          <= slot_i[s].pc;
                    exe_o[s].op_class    <= slot_i[s].op_class;
                    exe_o[s].aluop       <= slot_i[s].aluop;
                    exe_o[s].write_valid <= slot_i[s].write_valid;
                    exe_o[s].write_addr  <= slot_i[s].write_addr;
                    exe_o[s].operand1    <= operand_i[s][0];
                    // Immediate takes the second operand position
                    exe_o[s].operand2    <= slot_i[s].use_imm ? slot_i[s].imm : operand_i[s][1];
                    exe_o[s].imm         <= slot_i[s].imm;
                end else begin
                    exe_o[s] <= '0;
                end
            end
        end
    endgenerate

    // In-order issue, slot 1 never leaves ahead of slot 0
    a_no_lone_slot1: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_mask_i != 2'b10
    );

    // Execute sees a frozen stage while stalled
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall_i && !flush_i) |=> (exe_o == $past(exe_o))
    );

endmodule

// ==== dispatch_top.sv ====
`timescale 1ns/100ps

module dispatch_top (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  dual_issue_pkg::slot_t [dual_issue_pkg::ISSUE_W-1:0]   slot_i,
    input  dual_issue_pkg::fwd_t [dual_issue_pkg::FWD_N-1:0]      fwd_i,
    input  dual_issue_pkg::wb_t [dual_issue_pkg::ISSUE_W-1:0]     wb_i,
    input  logic                                                  stall_i,
    input  logic                                                  flush_i,
    input  logic                                                  block_i,
    output logic [dual_issue_pkg::ISSUE_W-1:0]                    accept_o,
    output logic                                                  is_pri_o,
    output dual_issue_pkg::issue_t [dual_issue_pkg::ISSUE_W-1:0]  exe_o
);

    logic [dual_issue_pkg::ISSUE_W-1:0]                                    issue_mask;
    logic [dual_issue_pkg::RD_N-1:0][dual_issue_pkg::REG_ADDR_W-1:0]       rf_raddr;
    logic [dual_issue_pkg::RD_N-1:0][dual_issue_pkg::DATA_W-1:0]           rf_rdata;
    logic [dual_issue_pkg::ISSUE_W-1:0][dual_issue_pkg::SRC_N-1:0][dual_issue_pkg::DATA_W-1:0]
                                                                           operand;

    issue_ctrl u_issue_ctrl (
        .slot_i       (slot_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .block_i      (block_i),
        .issue_mask_o (issue_mask),
        .accept_o     (accept_o),
        .is_pri_o     (is_pri_o)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_i    (wb_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

    // Read port s*SRC_N + r serves operand r of slot s
    generate
        for (genvar s = 0; s < dual_issue_pkg::ISSUE_W; s++) begin : g_slot
            for (genvar r = 0; r < dual_issue_pkg::SRC_N; r++) begin : g_src
                assign rf_raddr[s*dual_issue_pkg::SRC_N + r] = slot_i[s].read_addr[r];

                operand_forward u_operand_forward (
                    .rd_valid_i (slot_i[s].read_valid[r]),
                    .rd_addr_i  (slot_i[s].read_addr[r]),
                    .rf_data_i  (rf_rdata[s*dual_issue_pkg::SRC_N + r]),
                    .fwd_i      (fwd_i),
                    .operand_o  (operand[s][r])
                );
            end
        end
    endgenerate

    dispatch_regs u_dispatch_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_i       (slot_i),
        .operand_i    (operand),
        .issue_mask_i (issue_mask),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .exe_o        (exe_o)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // Two full cycles of reset, released between edges
    initial begin
        rst_n_o = 1'b0;
        #40 rst_n_o = 1'b1;
    end

endmodule

// ==== tb_dispatch.sv ====
`timescale 1ns/100ps

module tb_dispatch;

    typedef logic [159:0] val_t;

    typedef struct packed {
        dual_issue_pkg::slot_t [dual_issue_pkg::ISSUE_W-1:0] slot;
        dual_issue_pkg::fwd_t [dual_issue_pkg::FWD_N-1:0]    fwd;
        dual_issue_pkg::wb_t [dual_issue_pkg::ISSUE_W-1:0]   wb;
        logic [2:0]                                          ctrl;  // stall, flush, block
        logic [1:0]                                          exp_accept;
        logic                                                exp_pri;
        logic [1:0]                                          exp_valid;
    } row_t;

    logic                                                clk;
    logic                                                rst_n;
    dual_issue_pkg::slot_t [dual_issue_pkg::ISSUE_W-1:0] slot;
    dual_issue_pkg::fwd_t [dual_issue_pkg::FWD_N-1:0]    fwd;
    dual_issue_pkg::wb_t [dual_issue_pkg::ISSUE_W-1:0]   wb;
    logic                                                stall;
    logic                                                flush;
    logic                                                block;
    logic [1:0]                                          accept;
    logic                                                is_pri;
    dual_issue_pkg::issue_t [dual_issue_pkg::ISSUE_W-1:0] exe;

    row_t                         rows[$];
    logic [31:0]                  mirror [32];
    dual_issue_pkg::issue_t [1:0] model_exe;

    tb_clk_gen u_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dispatch_top u_dispatch_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .slot_i   (slot),
        .fwd_i    (fwd),
        .wb_i     (wb),
        .stall_i  (stall),
        .flush_i  (flush),
        .block_i  (block),
        .accept_o (accept),
        .is_pri_o (is_pri),
        .exe_o    (exe)
    );

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input string name, input val_t got, input val_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s expected %0h, got %0h", $time, name, exp, got);
            stop_run();
        end
    endtask

    function automatic dual_issue_pkg::slot_t slot_of(logic [31:0] pc, int rs1, int rs2,
            int rd, dual_issue_pkg::op_class_e cls = dual_issue_pkg::OP_ALU);
        dual_issue_pkg::slot_t s;
        s = '0;
        s.valid = 1'b1;
        s.pc = pc;
        s.op_class = cls;
        s.aluop = pc[9:2];
        s.read_valid = 2'b11;
        s.read_addr[0] = 5'(rs1);
        s.read_addr[1] = 5'(rs2);
        s.write_valid = 1'b1;
        s.write_addr = 5'(rd);
        s.imm = ~pc;
        return s;
    endfunction

    function automatic dual_issue_pkg::fwd_t fwd_src(logic v, int addr, logic [31:0] data);
        dual_issue_pkg::fwd_t f;
        f.valid = v;
        f.addr = 5'(addr);
        f.data = data;
        return f;
    endfunction

    function automatic dual_issue_pkg::wb_t wb_port(int addr, logic [31:0] data);
        dual_issue_pkg::wb_t w;
        w.we = 1'b1;
        w.addr = 5'(addr);
        w.data = data;
        return w;
    endfunction

    function automatic void add_row(dual_issue_pkg::slot_t s0, dual_issue_pkg::slot_t s1,
            dual_issue_pkg::fwd_t [3:0] f, dual_issue_pkg::wb_t [1:0] w, logic [2:0] ctrl,
            logic [1:0] exp_accept, logic exp_pri, logic [1:0] exp_valid);
        row_t r;
        r.slot[0] = s0;
        r.slot[1] = s1;
        r.fwd = f;
        r.wb = w;
        r.ctrl = ctrl;
        r.exp_accept = exp_accept;
        r.exp_pri = exp_pri;
        r.exp_valid = exp_valid;
        rows.push_back(r);
    endfunction

    // Newest result first, register 0 is hardwired
    function automatic logic [31:0] model_operand(logic rd_valid, logic [4:0] addr,
            dual_issue_pkg::fwd_t [3:0] f);
        logic [31:0] value;
        logic        found;
        value = mirror[addr];
        found = 1'b0;
        if (rd_valid && addr != 5'd0) begin
            for (int i = 0; i < dual_issue_pkg::FWD_N; i++) begin
                if (!found && f[i].valid && f[i].addr == addr) begin
                    value = f[i].data;
                    found = 1'b1;
                end
            end
        end
        return value;
    endfunction

    function automatic dual_issue_pkg::issue_t expect_issue(dual_issue_pkg::slot_t s,
            dual_issue_pkg::fwd_t [3:0] f);
        dual_issue_pkg::issue_t e;
        e = '0;
        e.valid = 1'b1;
        e.pc = s.pc;
        e.op_class = s.op_class;
        e.aluop = s.aluop;
        e.write_valid = s.write_valid;
        e.write_addr = s.write_addr;
        e.operand1 = model_operand(s.read_valid[0], s.read_addr[0], f);
        e.operand2 = s.use_imm ? s.imm : model_operand(s.read_valid[1], s.read_addr[1], f);
        e.imm = s.imm;
        return e;
    endfunction

    // Port 1 goes last and wins a clash
    function automatic void apply_writeback(dual_issue_pkg::wb_t [1:0] w);
        for (int p = 0; p < 2; p++) begin
            if (w[p].we && w[p].addr != 5'd0) begin
                mirror[w[p].addr] = w[p].data;
            end
        end
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) begin
                $display("Reset was not released within 10 clock cycles");
                stop_run();
            end
        end
    endtask

    task automatic build_preload();
        dual_issue_pkg::wb_t [1:0] w;
        for (int a = 1; a < 32; a += 2) begin
            w = '0;
            w[0] = wb_port(a, $urandom);
            if (a + 1 < 32) begin
                w[1] = wb_port(a + 1, $urandom);
            end
            add_row('0, '0, '0, w, 3'b000, 2'b00, 1'b0, 2'b00);
        end
    endtask

    task automatic build_table();
        dual_issue_pkg::fwd_t [3:0] f;
        dual_issue_pkg::slot_t      s;
        dual_issue_pkg::wb_t [1:0]  w;
        add_row(slot_of(32'h100, 1, 2, 3), slot_of(32'h104, 4, 5, 6), '0, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        // Single issue causes
        add_row(slot_of(32'h108, 1, 2, 7), slot_of(32'h10c, 7, 3, 8), '0, '0,
                3'b000, 2'b01, 1'b0, 2'b01);
        add_row(slot_of(32'h110, 1, 2, 9, dual_issue_pkg::OP_MEM), slot_of(32'h114, 4, 5, 10),
                '0, '0, 3'b000, 2'b01, 1'b0, 2'b01);
        add_row(slot_of(32'h118, 1, 2, 11), slot_of(32'h11c, 4, 5, 12, dual_issue_pkg::OP_MEM),
                '0, '0, 3'b000, 2'b01, 1'b0, 2'b01);
        add_row(slot_of(32'h120, 1, 2, 13, dual_issue_pkg::OP_CSR), slot_of(32'h124, 4, 5, 14),
                '0, '0, 3'b000, 2'b01, 1'b0, 2'b01);
        add_row(slot_of(32'h128, 1, 2, 15, dual_issue_pkg::OP_PRIV), slot_of(32'h12c, 4, 5, 16),
                '0, '0, 3'b000, 2'b01, 1'b1, 2'b01);
        add_row(slot_of(32'h130, 1, 2, 17), slot_of(32'h134, 4, 5, 18, dual_issue_pkg::OP_TRAP),
                '0, '0, 3'b000, 2'b01, 1'b0, 2'b01);
        // Empty slot 1 is drained along with slot 0
        add_row(slot_of(32'h138, 3, 4, 19), '0, '0, '0, 3'b000, 2'b11, 1'b0, 2'b01);
        // All four sources hit r9, then drop them one by one
        f = {fwd_src(1'b1, 9, 32'hd0d0_0003), fwd_src(1'b1, 9, 32'hc0c0_0002),
             fwd_src(1'b1, 9, 32'hb0b0_0001), fwd_src(1'b1, 9, 32'ha0a0_0000)};
        add_row(slot_of(32'h140, 9, 10, 20), slot_of(32'h144, 11, 12, 21), f, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        f[0].valid = 1'b0;
        add_row(slot_of(32'h148, 9, 10, 20), slot_of(32'h14c, 11, 12, 21), f, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        f[0] = fwd_src(1'b1, 12, 32'he0e0_000c);
        f[1].valid = 1'b0;
        add_row(slot_of(32'h150, 9, 10, 20), slot_of(32'h154, 11, 12, 21), f, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        f[2].valid = 1'b0;
        add_row(slot_of(32'h158, 9, 10, 20), slot_of(32'h15c, 11, 12, 21), f, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        f = '0;
        f[0] = fwd_src(1'b1, 0, 32'hdead_beef);
        add_row(slot_of(32'h160, 0, 0, 22), slot_of(32'h164, 1, 2, 23), f, '0,
                3'b000, 2'b11, 1'b0, 2'b11);
        s = slot_of(32'h168, 5, 6, 24);
        s.use_imm = 1'b1;
        s.imm = 32'h0000_07ff;
        add_row(s, slot_of(32'h16c, 7, 8, 25), '0, '0, 3'b000, 2'b11, 1'b0, 2'b11);
        // Stall holds, flush wins over stall
        add_row(slot_of(32'h170, 1, 2, 26, dual_issue_pkg::OP_PRIV), slot_of(32'h174, 4, 5, 27),
                '0, '0, 3'b100, 2'b00, 1'b0, 2'b11);
        add_row(slot_of(32'h178, 1, 2, 3), slot_of(32'h17c, 4, 5, 6), '0, '0,
                3'b110, 2'b00, 1'b0, 2'b00);
        // Writes land at the edge, same-cycle reads see old data
        w = {wb_port(20, 32'hbeef_0020), wb_port(5, 32'hcafe_0005)};
        add_row(slot_of(32'h180, 1, 2, 3), slot_of(32'h184, 4, 5, 6), '0, w,
                3'b000, 2'b11, 1'b0, 2'b11);
        w = {wb_port(21, 32'h2222_2222), wb_port(21, 32'h1111_1111)};
        add_row(slot_of(32'h188, 1, 2, 28, dual_issue_pkg::OP_PRIV), slot_of(32'h18c, 4, 5, 29),
                '0, w, 3'b010, 2'b01, 1'b0, 2'b00);
        w = '0;
        w[0] = wb_port(5, 32'h5555_0005);
        add_row(slot_of(32'h190, 5, 20, 27), slot_of(32'h194, 21, 1, 28), '0, w,
                3'b000, 2'b11, 1'b0, 2'b11);
        add_row(slot_of(32'h198, 1, 2, 3), slot_of(32'h19c, 4, 5, 6), '0, '0,
                3'b001, 2'b00, 1'b0, 2'b00);
        add_row(slot_of(32'h1a0, 5, 21, 29), '0, '0, '0, 3'b000, 2'b11, 1'b0, 2'b01);
    endtask

    task automatic run_row(input row_t r, input int idx);
        dual_issue_pkg::issue_t [1:0] next_exe;
        next_exe = model_exe;
        slot = r.slot;
        fwd = r.fwd;
        wb = r.wb;
        {stall, flush, block} = r.ctrl;
        for (int s = 0; s < 2; s++) begin
            if (r.ctrl[1]) begin
                next_exe[s] = '0;
            end else if (!r.ctrl[2]) begin
                next_exe[s] = r.exp_valid[s] ? expect_issue(r.slot[s], r.fwd) : '0;
            end
        end
        #1;
        check($sformatf("accept_o, row %0d", idx), val_t'(accept), val_t'(r.exp_accept));
        check($sformatf("is_pri_o, row %0d", idx), val_t'(is_pri), val_t'(r.exp_pri));
        @(posedge clk);
        #2;
        apply_writeback(r.wb);
        model_exe = next_exe;
        for (int s = 0; s < 2; s++) begin
            check($sformatf("exe_o[%0d].valid, row %0d", s, idx), val_t'(exe[s].valid),
                  val_t'(r.exp_valid[s]));
            check($sformatf("exe_o[%0d], row %0d", s, idx), val_t'(exe[s]),
                  val_t'(model_exe[s]));
        end
    endtask

    initial begin
        #20000;
        $display("Run did not finish within 20 us");
        stop_run();
    end

    initial begin
        slot = '0;
        fwd = '0;
        wb = '0;
        stall = 1'b0;
        flush = 1'b0;
        block = 1'b0;
        model_exe = '0;
        for (int a = 0; a < 32; a++) begin
            mirror[a] = '0;
        end
        void'($urandom(80143));
        build_preload();
        build_table();
        wait_reset_release();
        @(posedge clk);
        #2;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i], i);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== dispatch_top.f ====
dual_issue_pkg.sv
issue_ctrl.sv
reg_file.sv
operand_forward.sv
dispatch_regs.sv
dispatch_top.sv
tb_clk_gen.sv
tb_dispatch.sv

// ==== Makefile ====
TOP := tb_dispatch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f dispatch_top.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
